//--- verif/qla_stim.txt
// op a1 a2 a3 a4 (hex): 0 idle, 1 write addr data, 2 read addr expected,
// 3 sample fb0..fb3, 4 ports amp_disable {cmd1,cmd0} {cmd3,cmd2}, f end
2 0000 000000f0 0 0
2 0001 00000000 0 0
2 0011 00000000 0 0
2 0010 00000000 0 0
2 0041 00000000 0 0
2 0004 00000005 0 0
4 f 00000000 00000000 0
1 0011 00000064 0 0
2 0011 00000064 0 0
1 0021 000000c8 0 0
1 0031 0000012c 0 0
1 0041 00000190 0 0
2 0041 00000190 0 0
4 f 00c80064 0190012c 0
1 1011 0000ffff 0 0
1 0012 00001234 0 0
2 1011 00000000 0 0
2 0012 00000000 0 0
2 0011 00000064 0 0
1 0001 0000000f 0 0
2 0000 00000000 0 0
4 0 00c80064 0190012c 0
3 0050 01b0 0100 0100
3 0050 01b0 0100 0100
4 0 00c80064 0190012c 0
3 0050 01b0 0100 0100
4 2 00c80064 0190012c 0
2 0000 00000022 0 0
2 0020 000001b0 0 0
0 0 0 0 0
1 0001 0000020f 0 0
4 0 00c80064 0190012c 0
3 00d8 0100 0300 0100
3 00d8 0100 0300 0100
3 00d8 0100 0100 0100
3 00d8 0100 0300 0100
3 00d8 0100 0300 0100
4 0 00c80064 0190012c 0
2 0030 00000300 0 0
2 0010 000000d8 0 0
1 0001 00000005 0 0
4 a 00c80064 0190012c 0
2 0000 000000a0 0 0
f 0 0 0 0

//--- sources.f
+incdir+design
design/qla_pkg.sv
design/qla_board_regs.sv
design/qla_dac_regs.sv
design/qla_safety_check.sv
design/qla_top.sv
verif/qla_tb.sv

//--- Bender.yml
package:
  name: qla_regbank

sources:
  - include_dirs:
      - design
    files:
      - design/qla_pkg.sv
      - design/qla_board_regs.sv
      - design/qla_dac_regs.sv
      - design/qla_safety_check.sv
      - design/qla_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - verif/qla_tb.sv

//--- verif/qla_tb.sv
// qla register bank testbench
// replays host accesses and feedback samples from the stim file, checks responses
`timescale 1ns/10ps
`include "qla_params.svh"

module qla_tb;

    // one record is op plus four argument words
    localparam int MAX_OPS    = 64;
    localparam int REC_WORDS  = 5;
    localparam int RD_TIMEOUT = 20;

    logic                sysclk;
    logic                rst_n;
    qla_pkg::host_req_t  req;
    qla_pkg::host_rsp_t  rsp;
    logic [3:0]          board_id;
    logic                fb_valid;
    qla_pkg::cur_t       fb_sample [`QLA_NUM_AXES];
    qla_pkg::cur_t       cur_cmd   [`QLA_NUM_AXES];
    qla_pkg::axis_mask_t amp_disable;

    logic [31:0] stim_mem [MAX_OPS*REC_WORDS];
    integer      seed;

    qla_top DUT (
        .sysclk      (sysclk),
        .rst_n       (rst_n),
        .req         (req),
        .rsp         (rsp),
        .board_id    (board_id),
        .fb_valid    (fb_valid),
        .fb_sample   (fb_sample),
        .cur_cmd     (cur_cmd),
        .amp_disable (amp_disable)
    );

    // 40 ns clock
    initial begin
        sysclk = 1'b0;
        forever #20 sysclk = ~sysclk;
    end

    // ----------------------------------------------------------------------
    // failure and compare
    // ----------------------------------------------------------------------
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("ERROR %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    // ----------------------------------------------------------------------
    // bus operations
    // ----------------------------------------------------------------------
    // strobe for one cycle, the next op drops it
    task automatic host_write(input logic [15:0] addr, input logic [31:0] data);
        @(posedge sysclk);
        req.wr_strobe <= 1'b1;
        req.rd_strobe <= 1'b0;
        req.addr      <= addr;
        req.wdata     <= data;
    endtask

    task automatic host_read(input logic [15:0] addr, input logic [31:0] exp);
        int waited;
        @(posedge sysclk);
        req.wr_strobe <= 1'b0;
        req.rd_strobe <= 1'b1;
        req.addr      <= addr;
        @(posedge sysclk);
        req.rd_strobe <= 1'b0;
        waited = 0;
        // sample away from the active edge
        @(negedge sysclk);
        while (!rsp.rd_valid) begin
            waited++;
            if (waited > RD_TIMEOUT) begin
                abort_run($sformatf("no read response for address %h", addr));
            end
            @(negedge sysclk);
        end
        // latency is fixed at one cycle
        check_value("rd_latency", waited, 0);
        check_value($sformatf("rdata[%h]", addr), rsp.rdata, exp);
    endtask

    task automatic drive_sample(input logic [31:0] fb [4]);
        @(posedge sysclk);
        req.wr_strobe <= 1'b0;
        req.rd_strobe <= 1'b0;
        fb_valid      <= 1'b1;
        for (int a = 0; a < `QLA_NUM_AXES; a++) begin
            fb_sample[a] <= fb[a][15:0];
        end
        @(posedge sysclk);
        fb_valid <= 1'b0;
    endtask

    // cmd words packed two axes per quadlet, axis 0 low
    task automatic check_ports(input logic [31:0] exp_dis, input logic [31:0] exp_c10,
                               input logic [31:0] exp_c32);
        @(posedge sysclk);
        req.wr_strobe <= 1'b0;
        req.rd_strobe <= 1'b0;
        @(negedge sysclk);
        check_value("amp_disable", {28'h0, amp_disable}, exp_dis);
        check_value("cur_cmd[1:0]", {cur_cmd[1], cur_cmd[0]}, exp_c10);
        check_value("cur_cmd[3:2]", {cur_cmd[3], cur_cmd[2]}, exp_c32);
    endtask

    task automatic idle_gap();
        int gap;
        gap = $unsigned($random(seed)) % 4;
        @(posedge sysclk);
        req.wr_strobe <= 1'b0;
        req.rd_strobe <= 1'b0;
        repeat (gap) @(posedge sysclk);
    endtask

    // ----------------------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------------------
    initial begin
        int          op_idx;
        logic [31:0] op;
        logic [31:0] arg [4];
        logic        done;
        rst_n    = 1'b0;
        req      = '0;
        board_id = 4'h5;
        fb_valid = 1'b0;
        for (int a = 0; a < `QLA_NUM_AXES; a++) begin
            fb_sample[a] = '0;
        end
        seed = 56198;
        $readmemh("verif/qla_stim.txt", stim_mem);
        repeat (10) @(posedge sysclk);
        rst_n <= 1'b1;
        op_idx = 0;
        done   = 1'b0;
        while (!done) begin
            if (op_idx >= MAX_OPS) begin
                abort_run("stim file has no end record");
            end
            op = stim_mem[op_idx*REC_WORDS];
            for (int w = 0; w < 4; w++) begin
                arg[w] = stim_mem[op_idx*REC_WORDS + w + 1];
            end
            case (op)
                32'h0:   idle_gap();
                32'h1:   host_write(arg[0][15:0], arg[1]);
                32'h2:   host_read(arg[0][15:0], arg[1]);
                32'h3:   drive_sample(arg);
                32'h4:   check_ports(arg[0], arg[1], arg[2]);
                32'hf:   done = 1'b1;
                default: abort_run($sformatf("bad stim op %h in record %0d", op, op_idx));
            endcase
            op_idx++;
        end
        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- design/qla_top.sv
// qla host register bank top
// board regs, axis command regs and one safety monitor per axis
`timescale 1ns/10ps
`include "qla_params.svh"

module qla_top (
    input  logic                sysclk,
    input  logic                rst_n,
    input  qla_pkg::host_req_t  req,
    output qla_pkg::host_rsp_t  rsp,
    input  logic [3:0]          board_id,
    input  logic                fb_valid,
    input  qla_pkg::cur_t       fb_sample [`QLA_NUM_AXES],
    output qla_pkg::cur_t       cur_cmd   [`QLA_NUM_AXES],
    output qla_pkg::axis_mask_t amp_disable
);

    // ----------------------------------------------------------------------
    // local wires
    // ----------------------------------------------------------------------
    qla_pkg::axis_mask_t wr_axis;
    qla_pkg::cur_t       wdata_cur;
    qla_pkg::axis_mask_t safety_clear;
    qla_pkg::cur_t       fb_rd [`QLA_NUM_AXES];
    qla_pkg::axis_mask_t fault;

    // channel 0 decode and read path
    qla_board_regs u_board_regs (
        .sysclk       (sysclk),
        .rst_n        (rst_n),
        .req          (req),
        .rsp          (rsp),
        .wr_axis      (wr_axis),
        .wdata_cur    (wdata_cur),
        .safety_clear (safety_clear),
        .cmd_rd       (cur_cmd),
        .fb_rd        (fb_rd),
        .fault        (fault),
        .board_id     (board_id),
        .amp_disable  (amp_disable)
    );

    // commands go straight out to the dac side
    qla_dac_regs u_dac_regs (
        .sysclk    (sysclk),
        .rst_n     (rst_n),
        .wr_axis   (wr_axis),
        .wdata_cur (wdata_cur),
        .cur_cmd   (cur_cmd)
    );

    // fb vs 2 * cmd, one monitor per axis
    for (genvar a = 0; a < `QLA_NUM_AXES; a++) begin : g_safe
        qla_safety_check u_safety (
            .sysclk   (sysclk),
            .rst_n    (rst_n),
            .fb_valid (fb_valid),
            .fb_in    (fb_sample[a]),
            .cmd      (cur_cmd[a]),
            .clear    (safety_clear[a]),
            .fb_rd    (fb_rd[a]),
            .fault    (fault[a])
        );
    end

endmodule

//--- design/qla_safety_check.sv
// qla per-axis safety monitor
// stores feedback, trips a fault after repeated over-current samples
`timescale 1ns/10ps
`include "qla_params.svh"

module qla_safety_check (
    input  logic          sysclk,
    input  logic          rst_n,
    input  logic          fb_valid,
    input  qla_pkg::cur_t fb_in,
    input  qla_pkg::cur_t cmd,
    input  logic          clear,
    output qla_pkg::cur_t fb_rd,
    output logic          fault
);

    localparam int CNT_W = $clog2(`QLA_SAFETY_COUNT + 1);

    qla_pkg::safety_state_t state_q;
    logic [CNT_W-1:0]       cnt_q;
    logic [17:0]            limit;
    logic                   over;

    // ----------------------------------------------------------------------
    // limit compare
    // ----------------------------------------------------------------------
    // 2 * cmd + margin, two extra bits so nothing wraps
    assign limit = {1'b0, cmd, 1'b0} + 18'(`QLA_SAFETY_MARGIN);
    // live sample, not the stored one
    assign over  = ({2'b00, fb_in} > limit);

    // stored sample for host readback
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            fb_rd <= '0;
        end else if (fb_valid) begin
            fb_rd <= fb_in;
        end
    end

    // ----------------------------------------------------------------------
    // trip fsm
    // ----------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (!rst_n || clear) begin
            state_q <= qla_pkg::SAFE_IDLE;
            cnt_q   <= '0;
        end else if (fb_valid) begin
            case (state_q)
                qla_pkg::SAFE_IDLE, qla_pkg::SAFE_COUNTING: begin
                    if (!over) begin
                        // any good sample restarts the count
                        state_q <= qla_pkg::SAFE_IDLE;
                        cnt_q   <= '0;
                    end else if (cnt_q == CNT_W'(`QLA_SAFETY_COUNT - 1)) begin
                        state_q <= qla_pkg::SAFE_TRIPPED;
                    end else begin
                        state_q <= qla_pkg::SAFE_COUNTING;
                        cnt_q   <= cnt_q + 1'b1;
                    end
                end
                // held until clear
                default: state_q <= qla_pkg::SAFE_TRIPPED;
            endcase
        end
    end

    assign fault = (state_q == qla_pkg::SAFE_TRIPPED);

    // latched fault only released by host clear or reset
    a_fault_held: assert property (@(posedge sysclk)
        $fell(fault) |-> ($past(clear) || !$past(rst_n)));

endmodule

//--- design/qla_dac_regs.sv
// qla axis current command registers
// one command per axis, loaded by host writes, drives dac side and monitors
`timescale 1ns/10ps
`include "qla_params.svh"

module qla_dac_regs (
    input  logic                sysclk,
    input  logic                rst_n,
    input  qla_pkg::axis_mask_t wr_axis,
    input  qla_pkg::cur_t       wdata_cur,
    output qla_pkg::cur_t       cur_cmd [`QLA_NUM_AXES]
);

    // ----------------------------------------------------------------------
    // command registers
    // ----------------------------------------------------------------------
    // commands reset to zero so the amps see no drive after reset
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            for (int a = 0; a < `QLA_NUM_AXES; a++) begin
                cur_cmd[a] <= '0;
            end
        end else begin
            for (int a = 0; a < `QLA_NUM_AXES; a++) begin
                // new value visible the cycle after the strobe
                if (wr_axis[a]) begin
                    cur_cmd[a] <= wdata_cur;
                end
            end
        end
    end

    // ----------------------------------------------------------------------
    // checks
    // ----------------------------------------------------------------------
    // decoder in board regs selects at most one axis per write
    a_wr_onehot: assert property (@(posedge sysclk) disable iff (!rst_n)
        $onehot0(wr_axis));

endmodule

//--- design/qla_board_regs.sv
// qla board registers (channel 0)
// decodes host requests, holds amp enable mask, muxes read data
`timescale 1ns/10ps
`include "qla_params.svh"

module qla_board_regs (
    input  logic                  sysclk,
    input  logic                  rst_n,
    input  qla_pkg::host_req_t    req,
    output qla_pkg::host_rsp_t    rsp,
    output qla_pkg::axis_mask_t   wr_axis,
    output qla_pkg::cur_t         wdata_cur,
    output qla_pkg::axis_mask_t   safety_clear,
    input  qla_pkg::cur_t         cmd_rd [`QLA_NUM_AXES],
    input  qla_pkg::cur_t         fb_rd  [`QLA_NUM_AXES],
    input  qla_pkg::axis_mask_t   fault,
    input  logic [3:0]            board_id,
    output qla_pkg::axis_mask_t   amp_disable
);

    // ----------------------------------------------------------------------
    // address decode
    // ----------------------------------------------------------------------
    logic                in_region;
    logic [3:0]          chan;
    logic [3:0]          off;
    logic                wr_ctrl;
    qla_pkg::axis_mask_t amp_en;
    qla_pkg::reg_data_t  rd_word;
    logic                rd_valid_q;
    qla_pkg::reg_data_t  rdata_q;

    assign in_region = (req.addr[15:12] == `QLA_ADDR_REGION_BOARD);
    assign chan      = req.addr[7:4];
    assign off       = req.addr[3:0];

    // control write in channel 0
    assign wr_ctrl = req.wr_strobe && in_region && (chan == 4'd0) && (off == `QLA_OFF_CONTROL);

    // axis command strobes, channel 1..4 maps to axis 0..3
    always_comb begin
        for (int a = 0; a < `QLA_NUM_AXES; a++) begin
            wr_axis[a] = req.wr_strobe && in_region && (chan == 4'(a + 1))
                         && (off == `QLA_OFF_DAC_CTRL);
        end
    end

    // low half of the quadlet carries the command
    assign wdata_cur = req.wdata[15:0];

    // clear bits 11:8 of control, pulsed with the write
    assign safety_clear = wr_ctrl ? req.wdata[11:8] : '0;

    // ----------------------------------------------------------------------
    // amp enable mask
    // ----------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            amp_en <= '0;
        end else if (wr_ctrl) begin
            amp_en <= req.wdata[`QLA_NUM_AXES-1:0];
        end
    end

    // disabled unless enabled, faults override
    assign amp_disable = ~amp_en | fault;

    // ----------------------------------------------------------------------
    // read mux
    // ----------------------------------------------------------------------
    always_comb begin
        rd_word = '0;
        if (in_region && (chan == 4'd0)) begin
            case (off)
                `QLA_OFF_STATUS: begin
                    rd_word[`QLA_NUM_AXES-1:0]               = fault;
                    rd_word[2*`QLA_NUM_AXES-1:`QLA_NUM_AXES] = amp_disable;
                end
                `QLA_OFF_CONTROL:  rd_word[`QLA_NUM_AXES-1:0] = amp_en;
                `QLA_OFF_BOARD_ID: rd_word[3:0]               = board_id;
                default:           rd_word = '0;
            endcase
        end else if (in_region) begin
            // axis channels, unknown offsets stay zero
            for (int a = 0; a < `QLA_NUM_AXES; a++) begin
                if (chan == 4'(a + 1)) begin
                    if (off == `QLA_OFF_ADC_DATA) begin
                        rd_word[15:0] = fb_rd[a];
                    end else if (off == `QLA_OFF_DAC_CTRL) begin
                        rd_word[15:0] = cmd_rd[a];
                    end
                end
            end
        end
    end

    // one cycle read latency
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= req.rd_strobe;
        end
    end

    // data only captured on a read
    always_ff @(posedge sysclk) begin
        if (req.rd_strobe) begin
            rdata_q <= rd_word;
        end
    end

    assign rsp.rd_valid = rd_valid_q;
    assign rsp.rdata    = rdata_q;

    // ----------------------------------------------------------------------
    // checks
    // ----------------------------------------------------------------------
    // host never issues read and write at once
    a_no_rd_wr: assert property (@(posedge sysclk) disable iff (!rst_n)
        !(req.rd_strobe && req.wr_strobe));

endmodule

//--- design/qla_pkg.sv
// qla shared types
// register bus widths, host request/response structs, safety fsm states
`include "qla_params.svh"

package qla_pkg;

    // ----------------------------------------------------------------------
    // vector types
    // ----------------------------------------------------------------------
    typedef logic [15:0] reg_addr_t;
    typedef logic [31:0] reg_data_t;
    // unsigned current magnitude, same width for adc and dac side
    typedef logic [15:0] cur_t;
    // one bit per axis
    typedef logic [`QLA_NUM_AXES-1:0] axis_mask_t;

    // ----------------------------------------------------------------------
    // host side structs
    // ----------------------------------------------------------------------
    // single-cycle strobes, at most one high
    typedef struct packed {
        logic      wr_strobe;
        logic      rd_strobe;
        reg_addr_t addr;
        reg_data_t wdata;
    } host_req_t;

    // rd_valid one cycle after rd_strobe
    typedef struct packed {
        logic      rd_valid;
        reg_data_t rdata;
    } host_rsp_t;

    // per-axis over-current monitor
    typedef enum logic [1:0] {SAFE_IDLE, SAFE_COUNTING, SAFE_TRIPPED} safety_state_t;

endpackage

//--- design/qla_params.svh
// qla host register bank parameters
// axis count, address decode fields, register offsets, safety limits
`ifndef QLA_PARAMS_SVH
`define QLA_PARAMS_SVH

// number of motor axes on the board
`define QLA_NUM_AXES          4

// address bits 15:12 select the region, this bank is region 0
`define QLA_ADDR_REGION_BOARD 4'h0

// axis channel offsets, address bits 3:0 (channel in bits 7:4)
`define QLA_OFF_ADC_DATA      4'd0
`define QLA_OFF_DAC_CTRL      4'd1

// channel 0 offsets
`define QLA_OFF_STATUS        4'd0
`define QLA_OFF_CONTROL       4'd1
`define QLA_OFF_BOARD_ID      4'd4

// over-current limit is 2 * cmd + margin
`define QLA_SAFETY_MARGIN     16
// consecutive over-limit samples before the amp is cut
`define QLA_SAFETY_COUNT      3

`endif
